// ==== list.f ====
design/manycore_pkg.sv
design/spmd_loader.sv
design/bank_xbar.sv
design/boot_regs.sv
design/manycore_boot_top.sv
tb/tb_manycore_boot_assertions.sv
tb/tb_manycore_boot.sv

// ==== run.sh ====
#!/bin/sh
# build and run the boot endpoint testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_manycore_boot -o tb_sim -f list.f

# the runtime error limit keeps assertion failures from stopping the run early
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// ==== tb/tb_manycore_boot.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_manycore_boot;

  import manycore_pkg::*;

  localparam int num_banks_c  = 8;
  localparam int bank_words_c = 256;
  localparam int mem_words_c  = num_banks_c * bank_words_c;
  localparam int wait_limit_c = 400; // cycles for any single wait
  localparam int poll_limit_c = 100; // status reads
  localparam int load_pkts_c  = 20;
  localparam int busy_pkts_c  = 16;  // contended load
  localparam int net_pkts_c   = 24;

  logic                    clk;
  logic                    rst_n;
  logic                    wb_cyc, wb_stb, wb_we, wb_ack;
  logic [addr_width_c-1:0] wb_adr;
  logic [data_width_c-1:0] wb_dat_w, wb_dat_r;
  logic [data_width_c-1:0] rom_data;
  logic [addr_width_c-1:0] rom_addr;
  logic                    net_v, net_ready;
  store_pkt_s              net_pkt;

  logic [data_width_c-1:0] rom_mem [256];
  logic [data_width_c-1:0] ref_mem [mem_words_c];
  logic [mask_width_c-1:0] ref_known [mem_words_c]; // bytes written so far
  logic [15:0]             lfsr_q;
  int                      errors, checks, test_errs;

  assign rom_data = rom_mem[rom_addr[7:0]]; // combinational rom

  manycore_boot_top #(
    .num_banks_p  (num_banks_c),
    .bank_words_p (bank_words_c)
  ) uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_w),
    .wb_dat_o    (wb_dat_r),
    .wb_ack_o    (wb_ack),
    .rom_data_i  (rom_data),
    .rom_addr_o  (rom_addr),
    .net_v_i     (net_v),
    .net_pkt_i   (net_pkt),
    .net_ready_o (net_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb)
        lfsr_q = lfsr_q ^ 16'hb400;
      r = {r[30:0], lsb};
    end
    return r;
  endfunction

  function automatic logic [15:0] mem_addr(input logic [7:0] row, input logic [2:0] bank);
    return {5'b0, row, bank}; // ctrl flag 0 with the bank in the low bits
  endfunction

  // byte merge under the mask and control view stores skip memory
  function automatic void apply_store(input store_pkt_s pkt);
    int w;
    w = int'(pkt.addr[word_width_c-1:0]) % mem_words_c;
    if (!pkt.addr[addr_width_c-1])
    begin
      for (int i = 0; i < mask_width_c; i++)
      begin
        if (pkt.mask[i])
        begin
          ref_mem[w][8*i +: 8] = pkt.data[8*i +: 8];
          ref_known[w][i]      = 1'b1;
        end
      end
    end
  endfunction

  function automatic void build_program(input int n, input logic contended);
    logic [3:0] mask;
    logic [7:0] row;
    logic [2:0] bank;
    for (int k = 0; k < n; k++)
    begin
      row  = contended ? 8'(k) : 8'(rand_bits(5));
      bank = contended ? 3'd3 : 3'(rand_bits(3)); // contended load stays in bank 3
      mask = (k % 3 == 0) ? 4'hf : 4'(rand_bits(4));
      if (mask == 4'h0)
        mask = 4'h6;
      rom_mem[2*k]   = (32'(mask) << hdr_mask_lsb_c) | 32'(mem_addr(row, bank));
      rom_mem[2*k+1] = rand_bits(32);
    end
  endfunction

  function automatic store_pkt_s rom_pkt(input int k);
    store_pkt_s pkt;
    pkt.mask = rom_mem[2*k][hdr_mask_lsb_c +: mask_width_c];
    pkt.addr = rom_mem[2*k][addr_width_c-1:0];
    pkt.data = rom_mem[2*k+1];
    return pkt;
  endfunction

  task automatic fail_timeout(input string what);
    $display("timeout: %s did not arrive within %0d cycles", what, wait_limit_c);
    errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input logic [31:0] care);
    checks++;
    assert ((got & care) === (exp & care))
    else
    begin
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got & care, exp & care);
      errors++;
    end
  endtask

  task automatic wb_cycle(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
    int   waited;
    logic got;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    got      = 1'b0;
    while (!got && waited < wait_limit_c)
    begin
      @(posedge clk);
      waited++;
      got = wb_ack;
    end
    rdat = wb_dat_r; // data stands with the ack
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!got)
      fail_timeout("wb_ack_o");
  endtask

  task automatic reg_write(input logic [14:0] sel, input logic [31:0] dat);
    logic [31:0] unused;
    wb_cycle(1'b1, {1'b0, sel}, dat, unused);
  endtask

  task automatic reg_check(input string name, input logic [14:0] sel, input logic [31:0] exp);
    logic [31:0] got;
    wb_cycle(1'b0, {1'b0, sel}, '0, got);
    check_value($sformatf("wb_dat_o %s", name), got, exp, '1);
  endtask

  // memory window readback compares only bytes the model knows
  task automatic check_word(input int word);
    logic [31:0] got;
    logic [31:0] care;
    wb_cycle(1'b0, {1'b1, 15'(word)}, '0, got);
    for (int i = 0; i < mask_width_c; i++)
      care[8*i +: 8] = {8{ref_known[word][i]}};
    check_value($sformatf("wb_dat_o word 0x%03h", word), got, ref_mem[word], care);
  endtask

  // leaves valid up so back to back sends stream
  task automatic net_send(input store_pkt_s pkt);
    int   waited;
    logic got;
    @(negedge clk);
    net_v   = 1'b1;
    net_pkt = pkt;
    waited  = 0;
    got     = 1'b0;
    while (!got && waited < wait_limit_c)
    begin
      @(posedge clk);
      waited++;
      got = net_ready;
    end
    if (got)
      apply_store(pkt);
    else
      fail_timeout("net_ready_o");
  endtask

  task automatic net_idle();
    @(negedge clk);
    net_v = 1'b0;
  endtask

  task automatic wait_status(input int bit_idx, input string what);
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[bit_idx] && polls < poll_limit_c)
    begin
      wb_cycle(1'b0, {1'b0, reg_status_c}, '0, st);
      polls++;
    end
    if (!st[bit_idx])
    begin
      $display("timeout: status never showed %s after %0d polls", what, polls);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_errs)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - test_errs);
    test_errs = errors;
  endtask

  initial
  begin
    store_pkt_s  pkt;
    logic [15:0] cnt_val;
    logic [31:0] rdat;
    errors    = 0;
    checks    = 0;
    test_errs = 0;
    lfsr_q    = 16'd52089;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    net_v     = 1'b0;
    net_pkt   = '0;
    for (int i = 0; i < 256; i++)
      rom_mem[i] = 32'h5a5a_0000 ^ 32'(i); // fill tracks the address
    for (int i = 0; i < mem_words_c; i++)
    begin
      ref_mem[i]   = '0;
      ref_known[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reg_check("status", reg_status_c, 32'h0);
    reg_check("finish_code", reg_finish_code_c, 32'h0);
    reg_check("conflicts", reg_conflicts_c, 32'h0);
    end_test("reset state");

    build_program(load_pkts_c, 1'b0);
    reg_write(reg_pkt_count_c, 32'(load_pkts_c));
    reg_write(reg_ctrl_c, 32'h1);
    wait_status(1, "load_done");
    for (int k = 0; k < load_pkts_c; k++)
      apply_store(rom_pkt(k)); // loader stores land in rom order
    for (int k = 0; k < load_pkts_c; k++)
      check_word(int'(rom_mem[2*k][word_width_c-1:0]));
    end_test("program load");

    for (int j = 0; j < 6; j++)
    begin
      pkt.addr = mem_addr(8'(200 + j), 3'(rand_bits(3)));
      pkt.mask = 4'hf;
      pkt.data = rand_bits(32);
      net_send(pkt);
      for (int p = 0; p < 2; p++)
      begin
        // one end byte always set and the other clear
        pkt.mask = (4'(rand_bits(4)) & 4'h6) | ((p == 0) ? 4'h1 : 4'h8);
        pkt.data = rand_bits(32);
        net_send(pkt);
      end
      net_idle();
      check_word(int'(pkt.addr[word_width_c-1:0]));
    end
    end_test("masked network stores");

    build_program(busy_pkts_c, 1'b1);
    reg_write(reg_pkt_count_c, 32'(busy_pkts_c));
    reg_write(reg_ctrl_c, 32'h1);
    for (int j = 0; j < net_pkts_c; j++)
    begin
      pkt.addr = mem_addr(8'(100 + j), 3'd3); // same bank as the loader
      pkt.mask = (j % 2 == 0) ? 4'hf : (4'(rand_bits(4)) | 4'h1);
      pkt.data = rand_bits(32);
      net_send(pkt);
    end
    net_idle();
    wait_status(1, "load_done");
    for (int k = 0; k < busy_pkts_c; k++)
      apply_store(rom_pkt(k));
    for (int k = 0; k < busy_pkts_c; k++)
      check_word(int'(rom_mem[2*k][word_width_c-1:0]));
    for (int j = 0; j < net_pkts_c; j++)
      check_word(int'(mem_addr(8'(100 + j), 3'd3)));
    wb_cycle(1'b0, {1'b0, reg_conflicts_c}, '0, rdat);
    checks++;
    assert (rdat != 32'h0)
    else
    begin
      $display("conflict counter stayed at zero through a contended load");
      errors++;
    end
    reg_write(reg_conflicts_c, 32'h1);
    reg_check("conflicts", reg_conflicts_c, 32'h0);
    end_test("bank conflicts");

    pkt.addr = {1'b1, 12'h0, ctrl_sel_finish_c}; // control view with the finish select
    pkt.mask = 4'hf;
    pkt.data = rand_bits(32);
    net_send(pkt);
    net_idle();
    wait_status(2, "finished");
    reg_check("finish_code", reg_finish_code_c, pkt.data);
    end_test("finish");

    cnt_val = 16'(rand_bits(16));
    reg_write(reg_pkt_count_c, 32'(cnt_val));
    reg_check("pkt_count", reg_pkt_count_c, {16'h0, cnt_val});
    end_test("register readback");

    errors += uut.sva.fail_cnt; // bound protocol checks
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_manycore_boot_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_manycore_boot_assertions #(
  parameter int num_banks_p = 8
) (
  input wire                                    clk_i,
  input wire                                    rst_n_i,
  input wire                                    ld_v_i,
  input wire                                    ld_yumi_i,
  input wire [manycore_pkg::addr_width_c-1:0]   ld_addr_i,
  input wire                                    net_v_i,
  input wire                                    net_yumi_i,
  input wire [manycore_pkg::addr_width_c-1:0]   net_addr_i,
  input wire                                    rd_v_i,
  input wire                                    rd_yumi_i,
  input wire [manycore_pkg::word_width_c-1:0]   rd_word_i,
  input wire                                    ctrl_v_i,
  input wire                                    wb_cyc_i,
  input wire                                    wb_stb_i,
  input wire                                    wb_ack_i
);

  import manycore_pkg::*;

  localparam int lg_banks_lp = $clog2(num_banks_p);

  int                     fail_cnt = 0; // read by the testbench at the end
  logic                   ld_mem_g, net_mem_g, bank_clash;
  logic [lg_banks_lp-1:0] ld_bank, net_bank, rd_bank;

  // memory grants only, control packets skip the banks
  assign ld_mem_g  = ld_yumi_i & ~ld_addr_i[addr_width_c-1];
  assign net_mem_g = net_yumi_i & ~net_addr_i[addr_width_c-1];
  assign ld_bank   = ld_addr_i[lg_banks_lp-1:0];
  assign net_bank  = net_addr_i[lg_banks_lp-1:0];
  assign rd_bank   = rd_word_i[lg_banks_lp-1:0];

  assign bank_clash = (ld_mem_g & net_mem_g & (ld_bank == net_bank))
                    | (ld_mem_g & rd_yumi_i & (ld_bank == rd_bank))
                    | (net_mem_g & rd_yumi_i & (net_bank == rd_bank));

  ld_yumi_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ld_yumi_i |-> ld_v_i)
  else
  begin
    $error("loader yumi without valid");
    fail_cnt++;
  end

  net_yumi_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    net_yumi_i |-> net_v_i)
  else
  begin
    $error("network yumi without valid");
    fail_cnt++;
  end

  rd_yumi_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_yumi_i |-> rd_v_i)
  else
  begin
    $error("read port yumi without valid");
    fail_cnt++;
  end

  one_grant_per_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !bank_clash)
  else
  begin
    $error("two grants to one bank in the same cycle");
    fail_cnt++;
  end

  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
  else
  begin
    $error("wb_ack_o outside a bus cycle");
    fail_cnt++;
  end

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
  else
  begin
    $error("wb_ack_o held longer than one cycle");
    fail_cnt++;
  end

  ctrl_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_v_i |=> !ctrl_v_i)
  else
  begin
    $error("ctrl_v_o longer than one cycle");
    fail_cnt++;
  end

endmodule

// the top wires carry every crossbar port, so one instance sees both blocks
bind manycore_boot_top tb_manycore_boot_assertions #(
  .num_banks_p (num_banks_p)
) sva (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .ld_v_i     (ld_v),
  .ld_yumi_i  (ld_yumi),
  .ld_addr_i  (ld_pkt.addr),
  .net_v_i    (net_v_i),
  .net_yumi_i (net_ready_o),
  .net_addr_i (net_pkt_i.addr),
  .rd_v_i     (rd_v),
  .rd_yumi_i  (rd_yumi),
  .rd_word_i  (rd_word),
  .ctrl_v_i   (ctrl_v),
  .wb_cyc_i   (wb_cyc_i),
  .wb_stb_i   (wb_stb_i),
  .wb_ack_i   (wb_ack_o)
);

`default_nettype wire

// ==== design/manycore_boot_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module manycore_boot_top #(
  parameter int num_banks_p  = 8,
  parameter int bank_words_p = 256
) (
  input  wire                                    clk_i,
  input  wire                                    rst_n_i,
  input  wire                                    wb_cyc_i,
  input  wire                                    wb_stb_i,
  input  wire                                    wb_we_i,
  input  wire [manycore_pkg::addr_width_c-1:0]   wb_adr_i,
  input  wire [manycore_pkg::data_width_c-1:0]   wb_dat_i,
  output logic [manycore_pkg::data_width_c-1:0]  wb_dat_o,
  output logic                                   wb_ack_o,
  input  wire [manycore_pkg::data_width_c-1:0]   rom_data_i,
  output logic [manycore_pkg::addr_width_c-1:0]  rom_addr_o,
  input  wire                                    net_v_i,
  input  wire manycore_pkg::store_pkt_s          net_pkt_i,
  output logic                                   net_ready_o
);

  import manycore_pkg::*;

  // loader to crossbar port 0
  store_pkt_s                  ld_pkt;
  logic                        ld_v, ld_yumi;
  // load control
  logic                        start, busy, done;
  logic [cnt_width_c-1:0]      pkt_count;
  // memory window read port
  logic                        rd_v, rd_yumi;
  logic [word_width_c-1:0]     rd_word;
  logic [data_width_c-1:0]     rd_data;
  // control strobe and conflict flags
  logic [1:0]                  conflict;
  logic                        ctrl_v;
  logic [ctrl_sel_width_c-1:0] ctrl_sel;
  logic [data_width_c-1:0]     ctrl_data;

  spmd_loader loader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .pkt_count_i (pkt_count),
    .rom_data_i  (rom_data_i),
    .pkt_yumi_i  (ld_yumi),
    .rom_addr_o  (rom_addr_o),
    .pkt_v_o     (ld_v),
    .pkt_o       (ld_pkt),
    .busy_o      (busy),
    .done_o      (done)
  );

  bank_xbar #(
    .num_banks_p  (num_banks_p),
    .bank_words_p (bank_words_p)
  ) xbar (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ld_v_i      (ld_v),
    .ld_pkt_i    (ld_pkt),
    .ld_yumi_o   (ld_yumi),
    .net_v_i     (net_v_i),
    .net_pkt_i   (net_pkt_i),
    .net_yumi_o  (net_ready_o), // network sees yumi as ready
    .rd_v_i      (rd_v),
    .rd_word_i   (rd_word),
    .rd_yumi_o   (rd_yumi),
    .rd_data_o   (rd_data),
    .conflict_o  (conflict),
    .ctrl_v_o    (ctrl_v),
    .ctrl_sel_o  (ctrl_sel),
    .ctrl_data_o (ctrl_data)
  );

  boot_regs regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .start_o     (start),
    .pkt_count_o (pkt_count),
    .busy_i      (busy),
    .done_i      (done),
    .rd_v_o      (rd_v),
    .rd_word_o   (rd_word),
    .rd_yumi_i   (rd_yumi),
    .rd_data_i   (rd_data),
    .conflict_i  (conflict),
    .ctrl_v_i    (ctrl_v),
    .ctrl_sel_i  (ctrl_sel),
    .ctrl_data_i (ctrl_data)
  );

endmodule

`default_nettype wire

// ==== design/boot_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_regs (
  input  wire                                        clk_i,
  input  wire                                        rst_n_i,
  input  wire                                        wb_cyc_i,
  input  wire                                        wb_stb_i,
  input  wire                                        wb_we_i,
  input  wire [manycore_pkg::addr_width_c-1:0]       wb_adr_i,
  input  wire [manycore_pkg::data_width_c-1:0]       wb_dat_i,
  output logic [manycore_pkg::data_width_c-1:0]      wb_dat_o,
  output logic                                       wb_ack_o,
  output logic                                       start_o,
  output logic [manycore_pkg::cnt_width_c-1:0]       pkt_count_o,
  input  wire                                        busy_i,
  input  wire                                        done_i,
  output logic                                       rd_v_o,
  output logic [manycore_pkg::word_width_c-1:0]      rd_word_o,
  input  wire                                        rd_yumi_i,
  input  wire [manycore_pkg::data_width_c-1:0]       rd_data_i,
  input  wire [1:0]                                  conflict_i,
  input  wire                                        ctrl_v_i,
  input  wire [manycore_pkg::ctrl_sel_width_c-1:0]   ctrl_sel_i,
  input  wire [manycore_pkg::data_width_c-1:0]       ctrl_data_i
);

  import manycore_pkg::*;

  logic                    req;       // fresh wishbone cycle
  logic                    win;       // memory window
  logic                    reg_wr;
  logic [word_width_c-1:0] reg_sel;
  logic                    ack_q, rd_v_q, rd_wait_q, start_q;
  logic                    load_done_q, finished_q;
  logic [cnt_width_c-1:0]  pkt_count_q;
  logic [data_width_c-1:0] finish_code_q, conflict_cnt_q;
  logic [data_width_c-1:0] dat_q, reg_rdata;
  logic [word_width_c-1:0] rd_word_q;

  assign req     = wb_cyc_i & wb_stb_i & ~ack_q & ~rd_v_q & ~rd_wait_q;
  assign win     = wb_adr_i[mem_window_bit_c];
  assign reg_sel = wb_adr_i[word_width_c-1:0];
  assign reg_wr  = req & wb_we_i & ~win; // window writes are acked and dropped

  always_comb
  begin
    reg_rdata = '0;
    case (reg_sel)
      reg_ctrl_c:        reg_rdata[0] = busy_i;
      reg_pkt_count_c:   reg_rdata[cnt_width_c-1:0] = pkt_count_q;
      reg_status_c:      reg_rdata[2:0] = {finished_q, load_done_q, busy_i};
      reg_finish_code_c: reg_rdata = finish_code_q;
      reg_conflicts_c:   reg_rdata = conflict_cnt_q;
      default:           reg_rdata = '0;
    endcase
  end

  // bus handshake, registers ack next cycle, window read waits for the bank
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ack_q     <= 1'b0;
      rd_v_q    <= 1'b0;
      rd_wait_q <= 1'b0;
    end
    else
    begin
      ack_q     <= rd_wait_q; // read data valid now, ack next
      rd_wait_q <= rd_v_q & rd_yumi_i;
      if (rd_v_q & rd_yumi_i)
        rd_v_q <= 1'b0;
      if (req)
      begin
        if (win & ~wb_we_i)
          rd_v_q <= 1'b1;
        else
          ack_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req)
    begin
      dat_q     <= reg_rdata;
      rd_word_q <= wb_adr_i[word_width_c-1:0];
    end
    if (rd_wait_q)
      dat_q <= rd_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      start_q        <= 1'b0;
      pkt_count_q    <= '0;
      load_done_q    <= 1'b0;
      finished_q     <= 1'b0;
      finish_code_q  <= '0;
      conflict_cnt_q <= '0;
    end
    else
    begin
      start_q <= reg_wr & (reg_sel == reg_ctrl_c) & wb_dat_i[0]; // one cycle pulse
      if (reg_wr & (reg_sel == reg_pkt_count_c))
        pkt_count_q <= wb_dat_i[cnt_width_c-1:0];
      if (done_i)
        load_done_q <= 1'b1;
      else if (start_q)
        load_done_q <= 1'b0;
      if (ctrl_v_i & (ctrl_sel_i == ctrl_sel_finish_c))
      begin
        finished_q    <= 1'b1;
        finish_code_q <= ctrl_data_i;
      end
      if (reg_wr & (reg_sel == reg_conflicts_c))
        conflict_cnt_q <= '0;
      else if (|conflict_i)
        conflict_cnt_q <= conflict_cnt_q + 32'd1; // cycles, not events
    end
  end

  assign wb_dat_o    = dat_q;
  assign wb_ack_o    = ack_q;
  assign start_o     = start_q;
  assign pkt_count_o = pkt_count_q;
  assign rd_v_o      = rd_v_q;
  assign rd_word_o   = rd_word_q;

endmodule

`default_nettype wire

// ==== design/bank_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_xbar #(
  parameter int num_banks_p  = 8,
  parameter int bank_words_p = 256
) (
  input  wire                                        clk_i,
  input  wire                                        rst_n_i,
  input  wire                                        ld_v_i,
  input  wire manycore_pkg::store_pkt_s              ld_pkt_i,
  output logic                                       ld_yumi_o,
  input  wire                                        net_v_i,
  input  wire manycore_pkg::store_pkt_s              net_pkt_i,
  output logic                                       net_yumi_o,
  input  wire                                        rd_v_i,
  input  wire [manycore_pkg::word_width_c-1:0]       rd_word_i,
  output logic                                       rd_yumi_o,
  output logic [manycore_pkg::data_width_c-1:0]      rd_data_o,
  output logic [1:0]                                 conflict_o,
  output logic                                       ctrl_v_o,
  output logic [manycore_pkg::ctrl_sel_width_c-1:0]  ctrl_sel_o,
  output logic [manycore_pkg::data_width_c-1:0]      ctrl_data_o
);

  import manycore_pkg::*;

  localparam int lg_banks_lp = $clog2(num_banks_p);
  localparam int lg_words_lp = $clog2(bank_words_p);

  pkt_addr_u               ld_addr;
  pkt_addr_u               net_addr;
  logic [lg_banks_lp-1:0]  ld_bank, net_bank, rd_bank, rd_bank_q;
  logic [lg_words_lp-1:0]  ld_idx, net_idx, rd_idx;
  logic                    ld_mem_v, ld_ctl_v, net_mem_v, net_ctl_v;
  logic                    ld_ctl_go, net_ctl_go, net_mem_go;
  logic                    ctrl_v_q;
  logic [ctrl_sel_width_c-1:0] ctrl_sel_q;
  logic [data_width_c-1:0] ctrl_data_q;
  logic [data_width_c-1:0] bank_rdata [num_banks_p];

  assign ld_addr  = ld_pkt_i.addr;
  assign net_addr = net_pkt_i.addr;

  // interleaved: bank from low word bits, row above
  assign ld_bank  = ld_addr.mem.word[lg_banks_lp-1:0];
  assign ld_idx   = ld_addr.mem.word[lg_banks_lp +: lg_words_lp];
  assign net_bank = net_addr.mem.word[lg_banks_lp-1:0];
  assign net_idx  = net_addr.mem.word[lg_banks_lp +: lg_words_lp];
  assign rd_bank  = rd_word_i[lg_banks_lp-1:0];
  assign rd_idx   = rd_word_i[lg_banks_lp +: lg_words_lp];

  assign ld_mem_v  = ld_v_i & ~ld_addr.mem.ctrl;
  assign ld_ctl_v  = ld_v_i & ld_addr.ctl.ctrl;
  assign net_mem_v = net_v_i & ~net_addr.mem.ctrl;
  assign net_ctl_v = net_v_i & net_addr.ctl.ctrl;

  // control strobe taken at most every other cycle, keeps ctrl_v_o a pulse
  assign ld_ctl_go  = ld_ctl_v & ~ctrl_v_q;
  assign net_ctl_go = net_ctl_v & ~ctrl_v_q & ~ld_ctl_v; // loader first

  // fixed priority per bank: loader, network, read
  assign net_mem_go = net_mem_v & ~(ld_mem_v & (ld_bank == net_bank));
  assign rd_yumi_o  = rd_v_i
                    & ~(ld_mem_v & (ld_bank == rd_bank))
                    & ~(net_mem_go & (net_bank == rd_bank));

  assign ld_yumi_o  = ld_mem_v | ld_ctl_go; // loader memory writes never lose
  assign net_yumi_o = net_mem_go | net_ctl_go;

  assign conflict_o = {net_v_i & ~net_yumi_o, ld_v_i & ~ld_yumi_o}; // lost this cycle

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      ctrl_v_q <= 1'b0;
    else
      ctrl_v_q <= ld_ctl_go | net_ctl_go;
  end

  always_ff @(posedge clk_i)
  begin
    if (ld_ctl_go)
    begin
      ctrl_sel_q  <= ld_addr.ctl.sel;
      ctrl_data_q <= ld_pkt_i.data;
    end
    else if (net_ctl_go)
    begin
      ctrl_sel_q  <= net_addr.ctl.sel;
      ctrl_data_q <= net_pkt_i.data;
    end
    if (rd_yumi_o)
      rd_bank_q <= rd_bank; // steers the registered read data
  end

  for (genvar b = 0; b < num_banks_p; b++)
  begin : g_bank
    logic [data_width_c-1:0] mem_q [bank_words_p];
    logic                    ld_hit, net_hit, rd_hit;
    logic [mask_width_c-1:0] wr_mask;
    logic [data_width_c-1:0] wr_data;
    logic [lg_words_lp-1:0]  wr_idx;
    logic [data_width_c-1:0] rd_q;

    assign ld_hit  = ld_mem_v & (ld_bank == lg_banks_lp'(b));
    assign net_hit = net_mem_go & (net_bank == lg_banks_lp'(b));
    assign rd_hit  = rd_yumi_o & (rd_bank == lg_banks_lp'(b));

    // one writer per bank per cycle
    assign wr_mask = ld_hit ? ld_pkt_i.mask : (net_hit ? net_pkt_i.mask : '0);
    assign wr_data = ld_hit ? ld_pkt_i.data : net_pkt_i.data;
    assign wr_idx  = ld_hit ? ld_idx : net_idx;

    always_ff @(posedge clk_i)
    begin
      for (int i = 0; i < mask_width_c; i++)
      begin
        if (wr_mask[i])
          mem_q[wr_idx][8*i +: 8] <= wr_data[8*i +: 8]; // byte lanes under mask
      end
      if (rd_hit)
        rd_q <= mem_q[rd_idx];
    end

    assign bank_rdata[b] = rd_q;
  end

  assign rd_data_o   = bank_rdata[rd_bank_q]; // valid cycle after rd_yumi_o
  assign ctrl_v_o    = ctrl_v_q;
  assign ctrl_sel_o  = ctrl_sel_q;
  assign ctrl_data_o = ctrl_data_q;

endmodule

`default_nettype wire

// ==== design/spmd_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmd_loader (
  input  wire                                       clk_i,
  input  wire                                       rst_n_i,
  input  wire                                       start_i,
  input  wire [manycore_pkg::cnt_width_c-1:0]       pkt_count_i,
  input  wire [manycore_pkg::data_width_c-1:0]      rom_data_i,
  input  wire                                       pkt_yumi_i,
  output logic [manycore_pkg::addr_width_c-1:0]     rom_addr_o,
  output logic                                      pkt_v_o,
  output manycore_pkg::store_pkt_s                  pkt_o,
  output logic                                      busy_o,
  output logic                                      done_o
);

  import manycore_pkg::*;

  localparam logic [1:0] st_idle_c = 2'd0;
  localparam logic [1:0] st_hdr_c  = 2'd1; // rom at 2k
  localparam logic [1:0] st_data_c = 2'd2; // rom at 2k+1
  localparam logic [1:0] st_send_c = 2'd3; // hold packet until yumi

  logic [1:0]              state_q;
  logic [cnt_width_c-1:0]  count_q;  // latched at start
  logic [cnt_width_c-1:0]  idx_q;    // packet in flight
  logic                    done_q;
  logic                    last_pkt;
  logic [mask_width_c-1:0] mask_q;
  logic [addr_width_c-1:0] addr_q;
  logic [data_width_c-1:0] data_q;

  assign last_pkt = (idx_q + 16'd1) == count_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= st_idle_c;
      count_q <= '0;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0; // single cycle pulse
      case (state_q)
        st_idle_c:
          if (start_i)
          begin
            count_q <= pkt_count_i;
            idx_q   <= '0;
            if (pkt_count_i == '0)
              done_q <= 1'b1; // nothing to load
            else
              state_q <= st_hdr_c;
          end
        st_hdr_c:  state_q <= st_data_c;
        st_data_c: state_q <= st_send_c;
        st_send_c:
          if (pkt_yumi_i)
          begin
            if (last_pkt)
            begin
              done_q  <= 1'b1;
              state_q <= st_idle_c; // busy drops with done
            end
            else
            begin
              idx_q   <= idx_q + 16'd1;
              state_q <= st_hdr_c;
            end
          end
        default: state_q <= st_idle_c;
      endcase
    end
  end

  // packet fields straight from the combinational rom
  always_ff @(posedge clk_i)
  begin
    if (state_q == st_hdr_c)
    begin
      mask_q <= rom_data_i[hdr_mask_lsb_c +: mask_width_c];
      addr_q <= rom_data_i[addr_width_c-1:0];
    end
    if (state_q == st_data_c)
      data_q <= rom_data_i;
  end

  assign rom_addr_o = {idx_q[addr_width_c-2:0], state_q == st_data_c};
  assign pkt_v_o    = state_q == st_send_c;
  assign pkt_o.mask = mask_q;
  assign pkt_o.addr = addr_q;
  assign pkt_o.data = data_q;
  assign busy_o     = state_q != st_idle_c;
  assign done_o     = done_q;

endmodule

`default_nettype wire

// ==== design/manycore_pkg.sv ====
`default_nettype none

package manycore_pkg;

  localparam int addr_width_c = 16;               // packet address field
  localparam int data_width_c = 32;               // data word, also rom word
  localparam int mask_width_c = data_width_c / 8; // one bit per byte
  localparam int word_width_c = addr_width_c - 1; // address bits below the ctrl flag
  localparam int cnt_width_c  = 16;               // packet count

  // rom header word: address in the low half, byte mask just above it
  localparam int hdr_mask_lsb_c = addr_width_c;

  typedef struct packed {
    logic [mask_width_c-1:0] mask;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
  } store_pkt_s;

  localparam int ctrl_sel_width_c = 3;

  // memory view, bank from the low word bits so consecutive words interleave
  typedef struct packed {
    logic                    ctrl; // 0 for memory
    logic [word_width_c-1:0] word;
  } mem_addr_s;

  typedef struct packed {
    logic                                       ctrl;   // 1 for control space
    logic [word_width_c-ctrl_sel_width_c-1:0]   unused;
    logic [ctrl_sel_width_c-1:0]                sel;
  } ctrl_addr_s;

  typedef union packed {
    mem_addr_s  mem;
    ctrl_addr_s ctl;
  } pkt_addr_u;

  localparam logic [ctrl_sel_width_c-1:0] ctrl_sel_finish_c = 3'd0; // only defined select

  // wishbone register map, word addresses
  localparam logic [word_width_c-1:0] reg_ctrl_c        = 15'd0; // bit 0 starts a load
  localparam logic [word_width_c-1:0] reg_pkt_count_c   = 15'd1;
  localparam logic [word_width_c-1:0] reg_status_c      = 15'd2; // busy, load_done, finished
  localparam logic [word_width_c-1:0] reg_finish_code_c = 15'd3;
  localparam logic [word_width_c-1:0] reg_conflicts_c   = 15'd4; // write clears

  // set in the wishbone word address, low bits then index data memory
  localparam int mem_window_bit_c = word_width_c;

endpackage

`default_nettype wire
